//--- logic/jtag_pkg.sv
`default_nettype none

package jtag_pkg;

  // ieee 1149.1 tap controller states
  typedef enum logic [3:0] {
    TEST_LOGIC_RESET,
    RUN_TEST_IDLE,
    SELECT_DR_SCAN,
    CAPTURE_DR,
    SHIFT_DR,
    EXIT1_DR,
    PAUSE_DR,
    EXIT2_DR,
    UPDATE_DR,
    SELECT_IR_SCAN,
    CAPTURE_IR,
    SHIFT_IR,
    EXIT1_IR,
    PAUSE_IR,
    EXIT2_IR,
    UPDATE_IR
  } tap_state_e;

  // 5-bit instruction codes, unknown codes fall back to bypass
  typedef enum logic [4:0] {
    IDCODE    = 5'd1,
    DMIACCESS = 5'd17,
    BYPASS    = 5'd31
  } jtag_instr_e;

  // dmi op field, code 3 is reserved
  typedef enum logic [1:0] {
    NOP   = 2'd0,
    READ  = 2'd1,
    WRITE = 2'd2
  } dmi_op_e;

  // status reported back in the op slot on capture
  typedef enum logic [1:0] {
    OK    = 2'd0,
    ERROR = 2'd2,
    BUSY  = 2'd3
  } dmi_status_e;

  // chain layout, data in the low 32 bits, shifted lsb first
  typedef struct packed {
    logic [3:0]  addr;
    dmi_op_e     op;
    logic [31:0] data;
  } dmi_req_t;

  typedef struct packed {
    logic [31:0] data;
    dmi_status_e status;
  } dmi_rsp_t;

  localparam int unsigned DMI_DR_WIDTH = 38;

  // version, part number, manufacturer, fixed one
  localparam logic [31:0] IDCODE_DEFAULT = {4'h1, 16'h5c0d, 11'h2a7, 1'b1};

endpackage

`default_nettype wire

//--- logic/periph_pkg.sv
`default_nettype none

package periph_pkg;

  // register map seen through the dmi chain
  typedef enum logic [3:0] {
    GPIO_OUT   = 4'd0,
    GPIO_IN    = 4'd1,
    PWM_PERIOD = 4'd2,
    PWM_DUTY   = 4'd3,
    PWM_CTRL   = 4'd4
  } reg_addr_e;

  // gpio pins in each direction
  localparam int unsigned GPIO_W = 20;

  // pwm counter, period and duty width
  localparam int unsigned PWM_W = 16;

  // pwm settings as held by the register block
  typedef struct packed {
    // bit 0 of PWM_CTRL
    logic             enable;
    // counter wraps after period minus one ticks
    logic [PWM_W-1:0] period;
    // output high while counter below duty
    logic [PWM_W-1:0] duty;
  } pwm_cfg_t;

endpackage

`default_nettype wire

//--- logic/clk_tick_gen.sv
`timescale 1ns/1ps
`default_nettype none

module clk_tick_gen #(
  parameter logic [27:0] DIVISOR = 28'd4
) (
  input  logic clock_i,
  input  logic rst_i,
  output logic tick_o
);

  logic [27:0] count_q;

  // free running count, wraps at DIVISOR-1
  // tick is registered so it lands one cycle after the wrap value
  always_ff @(posedge clock_i) begin
    if (rst_i) begin
      count_q <= '0;
      tick_o  <= 1'b0;
    end else begin
      tick_o <= 1'b0;
      if (count_q >= DIVISOR - 28'd1) begin
        count_q <= '0;
        tick_o  <= 1'b1;
      end else begin
        count_q <= count_q + 28'd1;
      end
    end
  end

  // one-cycle enable, never a level
  a_tick_single : assert property (@(posedge clock_i) disable iff (rst_i)
    (DIVISOR > 28'd1 && tick_o) |=> !tick_o);

endmodule

`default_nettype wire

//--- logic/jtag_tap.sv
`timescale 1ns/1ps
`default_nettype none

module jtag_tap import jtag_pkg::*; #(
  parameter logic [31:0] JTAG_ID = IDCODE_DEFAULT
) (
  input  logic     clock_i,
  input  logic     rst_i,
  input  logic     tck_i,
  input  logic     tms_i,
  input  logic     tdi_i,
  output logic     tdo_o,
  output dmi_req_t dmi_req_o,
  output logic     dmi_req_valid_o,
  input  logic     dmi_req_ready_i,
  input  dmi_rsp_t dmi_rsp_i,
  input  logic     dmi_rsp_valid_i
);

  // pin order {tck, tms, tdi}
  logic [2:0]              pin_meta_q;
  logic [2:0]              pin_sync_q;
  logic                    tck_prev_q;
  logic                    tck_rise;
  logic                    tck_fall;
  logic                    tms;
  logic                    tdi;
  tap_state_e              state_q;
  tap_state_e              state_d;
  jtag_instr_e             ir_q;
  logic [4:0]              ir_shift_q;
  logic [31:0]             idcode_dr_q;
  logic                    bypass_dr_q;
  logic [DMI_DR_WIDTH-1:0] dmi_dr_q;
  dmi_req_t                dr_req;
  dmi_rsp_t                rsp_q;
  logic                    pending_q;
  logic                    busy_sticky_q;
  dmi_status_e             cap_status;
  logic                    dmi_update;
  logic                    dmi_capture;

  // two flops on every pin
  // tck edge found one stage later
  always_ff @(posedge clock_i) begin
    if (rst_i) begin
      pin_meta_q <= '0;
      pin_sync_q <= '0;
      tck_prev_q <= 1'b0;
    end else begin
      pin_meta_q <= {tck_i, tms_i, tdi_i};
      pin_sync_q <= pin_meta_q;
      tck_prev_q <= pin_sync_q[2];
    end
  end

  assign tck_rise = pin_sync_q[2] & ~tck_prev_q;
  assign tck_fall = ~pin_sync_q[2] & tck_prev_q;
  assign tms      = pin_sync_q[1];
  assign tdi      = pin_sync_q[0];

  // standard tap transitions picked by tms
  always_comb begin
    unique case (state_q)
      TEST_LOGIC_RESET: state_d = tms ? TEST_LOGIC_RESET : RUN_TEST_IDLE;
      RUN_TEST_IDLE:    state_d = tms ? SELECT_DR_SCAN : RUN_TEST_IDLE;
      SELECT_DR_SCAN:   state_d = tms ? SELECT_IR_SCAN : CAPTURE_DR;
      CAPTURE_DR:       state_d = tms ? EXIT1_DR : SHIFT_DR;
      SHIFT_DR:         state_d = tms ? EXIT1_DR : SHIFT_DR;
      EXIT1_DR:         state_d = tms ? UPDATE_DR : PAUSE_DR;
      PAUSE_DR:         state_d = tms ? EXIT2_DR : PAUSE_DR;
      EXIT2_DR:         state_d = tms ? UPDATE_DR : SHIFT_DR;
      UPDATE_DR:        state_d = tms ? SELECT_DR_SCAN : RUN_TEST_IDLE;
      SELECT_IR_SCAN:   state_d = tms ? TEST_LOGIC_RESET : CAPTURE_IR;
      CAPTURE_IR:       state_d = tms ? EXIT1_IR : SHIFT_IR;
      SHIFT_IR:         state_d = tms ? EXIT1_IR : SHIFT_IR;
      EXIT1_IR:         state_d = tms ? UPDATE_IR : PAUSE_IR;
      PAUSE_IR:         state_d = tms ? EXIT2_IR : PAUSE_IR;
      EXIT2_IR:         state_d = tms ? UPDATE_IR : SHIFT_IR;
      UPDATE_IR:        state_d = tms ? SELECT_DR_SCAN : RUN_TEST_IDLE;
      default:          state_d = TEST_LOGIC_RESET;
    endcase
  end

  // state and active instruction move only on a detected rise
  always_ff @(posedge clock_i) begin
    if (rst_i) begin
      state_q <= TEST_LOGIC_RESET;
      ir_q    <= IDCODE;
    end else if (tck_rise) begin
      state_q <= state_d;
      if (state_d == TEST_LOGIC_RESET) begin
        ir_q <= IDCODE;
      end else if (state_d == UPDATE_IR) begin
        case (ir_shift_q)
          IDCODE:    ir_q <= IDCODE;
          DMIACCESS: ir_q <= DMIACCESS;
          default:   ir_q <= BYPASS;
        endcase
      end
    end
  end

  // busy wins over the stored status on capture
  assign cap_status = (pending_q || busy_sticky_q) ? BUSY : rsp_q.status;

  // capture and shift with lsb leaving first
  always_ff @(posedge clock_i) begin
    if (tck_rise) begin
      case (state_q)
        CAPTURE_IR: ir_shift_q <= 5'b00001;
        SHIFT_IR:   ir_shift_q <= {tdi, ir_shift_q[4:1]};
        CAPTURE_DR: begin
          idcode_dr_q <= JTAG_ID;
          bypass_dr_q <= 1'b0;
          // status sits in the op slot
          dmi_dr_q    <= {4'b0, cap_status, rsp_q.data};
        end
        SHIFT_DR: begin
          case (ir_q)
            IDCODE:    idcode_dr_q <= {tdi, idcode_dr_q[31:1]};
            DMIACCESS: dmi_dr_q <= {tdi, dmi_dr_q[DMI_DR_WIDTH-1:1]};
            default:   bypass_dr_q <= tdi;
          endcase
        end
        default: ;
      endcase
    end
  end

  // tdo only moves on the falling tck
  // held low outside the shift states
  always_ff @(posedge clock_i) begin
    if (rst_i) begin
      tdo_o <= 1'b0;
    end else if (tck_fall) begin
      case (state_q)
        SHIFT_IR: tdo_o <= ir_shift_q[0];
        SHIFT_DR: begin
          case (ir_q)
            IDCODE:    tdo_o <= idcode_dr_q[0];
            DMIACCESS: tdo_o <= dmi_dr_q[0];
            default:   tdo_o <= bypass_dr_q;
          endcase
        end
        default: tdo_o <= 1'b0;
      endcase
    end
  end

  assign dr_req      = dmi_dr_q;
  assign dmi_update  = tck_rise && state_d == UPDATE_DR && ir_q == DMIACCESS &&
                       dr_req.op != NOP;
  assign dmi_capture = tck_rise && state_q == CAPTURE_DR && ir_q == DMIACCESS;

  // request stays pending until the response shows up
  always_ff @(posedge clock_i) begin
    if (rst_i) begin
      dmi_req_valid_o <= 1'b0;
      pending_q       <= 1'b0;
      busy_sticky_q   <= 1'b0;
      rsp_q           <= '0;
    end else begin
      if (dmi_req_valid_o && dmi_req_ready_i) begin
        dmi_req_valid_o <= 1'b0;
      end
      // response always taken without backpressure
      if (dmi_rsp_valid_i) begin
        rsp_q     <= dmi_rsp_i;
        pending_q <= 1'b0;
      end
      if (dmi_update) begin
        // overlapping op is dropped and flagged
        if (pending_q) begin
          busy_sticky_q <= 1'b1;
        end else begin
          dmi_req_valid_o <= 1'b1;
          pending_q       <= 1'b1;
        end
      end
      if (dmi_capture) begin
        busy_sticky_q <= 1'b0;
      end
    end
  end

  // request payload latched when issued
  always_ff @(posedge clock_i) begin
    if (dmi_update && !pending_q) begin
      dmi_req_o <= dr_req;
    end
  end

  a_req_stable : assert property (@(posedge clock_i) disable iff (rst_i)
    (dmi_req_valid_o && !dmi_req_ready_i) |=> (dmi_req_valid_o && $stable(dmi_req_o)));

  a_state_legal : assert property (@(posedge clock_i) disable iff (rst_i)
    !$isunknown(state_q));

endmodule

`default_nettype wire

//--- logic/periph_regs.sv
`timescale 1ns/1ps
`default_nettype none

module periph_regs import jtag_pkg::*; import periph_pkg::*; (
  input  logic              clock_i,
  input  logic              rst_i,
  input  dmi_req_t          dmi_req_i,
  input  logic              dmi_req_valid_i,
  output logic              dmi_req_ready_o,
  output dmi_rsp_t          dmi_rsp_o,
  output logic              dmi_rsp_valid_o,
  input  logic [GPIO_W-1:0] gpio_i,
  output logic [GPIO_W-1:0] gpio_o,
  output pwm_cfg_t          pwm_cfg_o
);

  reg_addr_e         addr;
  logic              req_fire;
  logic              wr_en;
  logic [31:0]       rd_data;
  dmi_status_e       rd_status;
  logic [GPIO_W-1:0] gpio_meta_q;
  logic [GPIO_W-1:0] gpio_sync_q;

  // no new request while a response is on its way back
  assign dmi_req_ready_o = ~dmi_rsp_valid_o;
  assign req_fire        = dmi_req_valid_i & dmi_req_ready_o;
  assign addr            = reg_addr_e'(dmi_req_i.addr);

  // two-flop input synchronizer
  always_ff @(posedge clock_i) begin
    gpio_meta_q <= gpio_i;
    gpio_sync_q <= gpio_meta_q;
  end

  // address decode, unmapped and read-only writes give an error
  always_comb begin
    rd_data   = '0;
    rd_status = OK;
    case (addr)
      GPIO_OUT:   rd_data = {{(32 - GPIO_W){1'b0}}, gpio_o};
      GPIO_IN: begin
        if (dmi_req_i.op == WRITE) begin
          rd_status = ERROR;
        end else begin
          rd_data = {{(32 - GPIO_W){1'b0}}, gpio_sync_q};
        end
      end
      PWM_PERIOD: rd_data = {{(32 - PWM_W){1'b0}}, pwm_cfg_o.period};
      PWM_DUTY:   rd_data = {{(32 - PWM_W){1'b0}}, pwm_cfg_o.duty};
      PWM_CTRL:   rd_data = {31'b0, pwm_cfg_o.enable};
      default:    rd_status = ERROR;
    endcase
  end

  assign wr_en = req_fire && dmi_req_i.op == WRITE && rd_status == OK;

  // registers and response strobe
  always_ff @(posedge clock_i) begin
    if (rst_i) begin
      gpio_o          <= '0;
      pwm_cfg_o       <= '0;
      dmi_rsp_valid_o <= 1'b0;
    end else begin
      dmi_rsp_valid_o <= req_fire;
      if (wr_en) begin
        case (addr)
          GPIO_OUT:   gpio_o <= dmi_req_i.data[GPIO_W-1:0];
          PWM_PERIOD: pwm_cfg_o.period <= dmi_req_i.data[PWM_W-1:0];
          PWM_DUTY:   pwm_cfg_o.duty <= dmi_req_i.data[PWM_W-1:0];
          PWM_CTRL:   pwm_cfg_o.enable <= dmi_req_i.data[0];
          default: ;
        endcase
      end
    end
  end

  // response payload, written back even for writes
  always_ff @(posedge clock_i) begin
    if (req_fire) begin
      dmi_rsp_o.data   <= rd_data;
      dmi_rsp_o.status <= rd_status;
    end
  end

  a_rsp_after_req : assert property (@(posedge clock_i) disable iff (rst_i)
    dmi_rsp_valid_o |-> $past(dmi_req_valid_i && dmi_req_ready_o));

endmodule

`default_nettype wire

//--- logic/pwm_gen.sv
`timescale 1ns/1ps
`default_nettype none

module pwm_gen import periph_pkg::*; (
  input  logic     clock_i,
  input  logic     rst_i,
  input  logic     tick_i,
  input  pwm_cfg_t cfg_i,
  output logic     pwm_o
);

  logic [PWM_W-1:0] count_q;
  logic [PWM_W-1:0] period_q;
  logic [PWM_W-1:0] duty_q;
  logic             last;

  // zero period wraps every tick
  assign last = (period_q == '0) || (count_q >= period_q - 1'b1);

  always_ff @(posedge clock_i) begin
    if (rst_i) begin
      count_q  <= '0;
      period_q <= '0;
      duty_q   <= '0;
      pwm_o    <= 1'b0;
    end else if (!cfg_i.enable) begin
      // idle, shadow follows the live settings
      count_q  <= '0;
      period_q <= cfg_i.period;
      duty_q   <= cfg_i.duty;
      pwm_o    <= 1'b0;
    end else begin
      if (tick_i) begin
        if (last) begin
          count_q  <= '0;
          // new settings only at the wrap
          period_q <= cfg_i.period;
          duty_q   <= cfg_i.duty;
        end else begin
          count_q <= count_q + 1'b1;
        end
      end
      // duty >= period keeps this high
      pwm_o <= (count_q < duty_q);
    end
  end

endmodule

`default_nettype wire

//--- logic/soc_top.sv
`timescale 1ns/1ps
`default_nettype none

module soc_top import jtag_pkg::*; import periph_pkg::*; #(
  parameter logic [27:0] DIVISOR = 28'd4,
  parameter logic [31:0] JTAG_ID = IDCODE_DEFAULT
) (
  input  logic              clock_i,
  input  logic              rst_i,
  input  logic              jtag_tck_i,
  input  logic              jtag_tms_i,
  input  logic              jtag_tdi_i,
  output logic              jtag_tdo_o,
  input  logic [GPIO_W-1:0] gpio_i,
  output logic [GPIO_W-1:0] gpio_o,
  output logic              pwm_o
);

  logic     tick;
  dmi_req_t dmi_req;
  logic     dmi_req_valid;
  logic     dmi_req_ready;
  dmi_rsp_t dmi_rsp;
  logic     dmi_rsp_valid;
  pwm_cfg_t pwm_cfg;

  // slow timebase for the pwm
  clk_tick_gen #(
    .DIVISOR (DIVISOR)
  ) clk_tick_gen_i (
    .clock_i (clock_i),
    .rst_i   (rst_i),
    .tick_o  (tick)
  );

  // debug port on the pins, sampled by clock_i
  jtag_tap #(
    .JTAG_ID (JTAG_ID)
  ) jtag_tap_i (
    .clock_i         (clock_i),
    .rst_i           (rst_i),
    .tck_i           (jtag_tck_i),
    .tms_i           (jtag_tms_i),
    .tdi_i           (jtag_tdi_i),
    .tdo_o           (jtag_tdo_o),
    .dmi_req_o       (dmi_req),
    .dmi_req_valid_o (dmi_req_valid),
    .dmi_req_ready_i (dmi_req_ready),
    .dmi_rsp_i       (dmi_rsp),
    .dmi_rsp_valid_i (dmi_rsp_valid)
  );

  // gpio and pwm registers behind the dmi
  periph_regs periph_regs_i (
    .clock_i         (clock_i),
    .rst_i           (rst_i),
    .dmi_req_i       (dmi_req),
    .dmi_req_valid_i (dmi_req_valid),
    .dmi_req_ready_o (dmi_req_ready),
    .dmi_rsp_o       (dmi_rsp),
    .dmi_rsp_valid_o (dmi_rsp_valid),
    .gpio_i          (gpio_i),
    .gpio_o          (gpio_o),
    .pwm_cfg_o       (pwm_cfg)
  );

  pwm_gen pwm_gen_i (
    .clock_i (clock_i),
    .rst_i   (rst_i),
    .tick_i  (tick),
    .cfg_i   (pwm_cfg),
    .pwm_o   (pwm_o)
  );

endmodule

`default_nettype wire

//--- sim/jtag_drive.svh
`ifndef JTAG_DRIVE_SVH
`define JTAG_DRIVE_SVH

// one tck period, low then high, each level held 8 clocks
// tdo sampled at the end of the low phase
task automatic tck_step(input logic tms_v, input logic tdi_v, output logic tdo_v);
  @(negedge clock);
  tms = tms_v;
  tdi = tdi_v;
  repeat (8) @(negedge clock);
  tdo_v = tdo;
  tck = 1'b1;
  repeat (8) @(negedge clock);
  tck = 1'b0;
endtask

// five tms-high edges, then on to run-test/idle
task automatic tap_reset();
  logic tdo_drop;
  repeat (5) begin
    tck_step(1'b1, 1'b0, tdo_drop);
  end
  tck_step(1'b0, 1'b0, tdo_drop);
endtask

// from test-logic-reset or idle into idle
task automatic tap_idle();
  logic tdo_drop;
  tck_step(1'b0, 1'b0, tdo_drop);
endtask

// idle to shift-ir, lsb first, back to idle through update-ir
task automatic shift_ir(input logic [4:0] instr);
  logic tdo_drop;
  tck_step(1'b1, 1'b0, tdo_drop);
  tck_step(1'b1, 1'b0, tdo_drop);
  tck_step(1'b0, 1'b0, tdo_drop);
  tck_step(1'b0, 1'b0, tdo_drop);
  for (int i = 0; i < 5; i++) begin
    // last bit leaves shift-ir
    tck_step(i == 4, instr[i], tdo_drop);
  end
  tck_step(1'b1, 1'b0, tdo_drop);
  tck_step(1'b0, 1'b0, tdo_drop);
endtask

// same walk on the dr side, n bits in and out
task automatic shift_dr(input logic [63:0] din, input int n, output logic [63:0] dout);
  logic bit_out;
  dout = '0;
  tck_step(1'b1, 1'b0, bit_out);
  tck_step(1'b0, 1'b0, bit_out);
  tck_step(1'b0, 1'b0, bit_out);
  for (int i = 0; i < n; i++) begin
    tck_step(i == n - 1, din[i], bit_out);
    dout[i] = bit_out;
  end
  // update-dr, then idle
  tck_step(1'b1, 1'b0, bit_out);
  tck_step(1'b0, 1'b0, bit_out);
endtask

`endif

//--- sim/soc_top_tb.sv
`timescale 1ns/1ps
`default_nettype none

module soc_top_tb import jtag_pkg::*; import periph_pkg::*; ();

  logic              clock;
  logic              rst;
  logic              tck;
  logic              tms;
  logic              tdi;
  logic              tdo;
  logic              pwm;
  logic [GPIO_W-1:0] gpio_in;
  logic [GPIO_W-1:0] gpio_out;
  logic [GPIO_W-1:0] gpio_rand;
  int                checks;

  soc_top #(
    .DIVISOR (28'd4)
  ) soc_top_i (
    .clock_i    (clock),
    .rst_i      (rst),
    .jtag_tck_i (tck),
    .jtag_tms_i (tms),
    .jtag_tdi_i (tdi),
    .jtag_tdo_o (tdo),
    .gpio_i     (gpio_in),
    .gpio_o     (gpio_out),
    .pwm_o      (pwm)
  );

  // 40 ns clock
  initial begin
    clock = 1'b0;
    forever begin
      #20 clock = ~clock;
    end
  end

  `include "jtag_drive.svh"

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (actual !== expected) begin
      $display("ERR %s expected %0h actual %0h", name, expected, actual);
      $display("Result: FAILED");
      $fatal(1, "mismatch in %s", name);
    end else begin
      checks++;
    end
  endtask

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Result: FAILED");
    $fatal(1, "%s", why);
  endtask

  task automatic dmi_scan(input logic [3:0] addr, input dmi_op_e op, input logic [31:0] data,
                          output logic [37:0] cap);
    logic [63:0] dout;
    shift_dr({26'd0, addr, op, data}, DMI_DR_WIDTH, dout);
    cap = dout[37:0];
  endtask

  // the next scan's capture brings back the response
  task automatic dmi_op(input logic [3:0] addr, input dmi_op_e op, input logic [31:0] data,
                        output logic [33:0] rsp);
    logic [37:0] cap;
    dmi_scan(addr, op, data, cap);
    dmi_scan(4'd0, NOP, 32'd0, cap);
    rsp = cap[33:0];
  endtask

  task automatic dmi_write_ok(input string name, input logic [3:0] addr,
                              input logic [31:0] data);
    logic [33:0] rsp;
    dmi_op(addr, WRITE, data, rsp);
    check_value(name, 64'(OK), 64'(rsp[33:32]));
  endtask

  // high cycles over one full pwm period of period*4 clocks
  task automatic measure_pwm(input string name, input logic en, input logic [15:0] period,
                             input logic [15:0] duty, input logic [63:0] expected);
    logic prev;
    int   window;
    int   highs;
    int   guard;
    window = int'(period) * 4;
    highs = 0;
    guard = 0;
    // settings pass straight through while the generator is off
    dmi_write_ok({name, " ctrl off"}, PWM_CTRL, 32'd0);
    dmi_write_ok({name, " period"}, PWM_PERIOD, {16'd0, period});
    dmi_write_ok({name, " duty"}, PWM_DUTY, {16'd0, duty});
    dmi_write_ok({name, " ctrl"}, PWM_CTRL, {31'd0, en});
    if (en && duty != 16'd0 && duty < period) begin
      // line up with the start of a period
      prev = 1'b1;
      while (!(pwm && !prev) && guard < 2 * window + 16) begin
        prev = pwm;
        @(negedge clock);
        guard++;
      end
      if (guard >= 2 * window + 16) begin
        fail_run({name, ": pwm output never went high"});
      end
    end
    for (int i = 0; i < window; i++) begin
      if (pwm) begin
        highs++;
      end
      @(negedge clock);
    end
    check_value({name, " high cycles"}, expected, 64'(highs));
  endtask

  // ready held low so the first op stays pending
  // while a second one is issued on top of it
  task automatic provoke_busy(input string name, input logic [3:0] addr,
                              input logic [31:0] data, input logic [63:0] expected);
    logic [37:0] cap;
    int          guard;
    guard = 0;
    force soc_top_i.periph_regs_i.dmi_req_ready_o = 1'b0;
    dmi_scan(addr, WRITE, data, cap);
    // capture of the second scan sees the first op pending
    // and its own op gets dropped
    dmi_scan(addr, WRITE, ~data, cap);
    check_value({name, " pending"}, expected, 64'(cap[33:32]));
    release soc_top_i.periph_regs_i.dmi_req_ready_o;
    while (soc_top_i.dmi_req_valid && guard < 64) begin
      @(negedge clock);
      guard++;
    end
    if (guard >= 64) begin
      fail_run({name, ": held request was never taken"});
    end
    dmi_scan(4'd0, NOP, 32'd0, cap);
    check_value({name, " sticky"}, expected, 64'(cap[33:32]));
    dmi_scan(4'd0, NOP, 32'd0, cap);
    check_value({name, " cleared"}, 64'(OK), 64'(cap[33:32]));
  endtask

  task automatic apply_vector(input logic [63:0] kind, input logic [63:0] addr,
                              input logic [63:0] data, input logic [63:0] expected,
                              input int lineno);
    string       name;
    logic [63:0] dout;
    logic [33:0] rsp;
    logic [31:0] rnd;
    name = $sformatf("line %0d", lineno);
    case (kind[7:0])
      8'h00: begin
        if (addr[0]) begin
          tap_reset();
        end else begin
          tap_idle();
        end
        shift_dr(64'd0, 32, dout);
        check_value({name, " idcode"}, expected, {32'd0, dout[31:0]});
      end
      8'h01: shift_ir(data[4:0]);
      8'h02: begin
        shift_dr({32'd0, data[31:0]}, 32, dout);
        check_value({name, " dr shift"}, expected, {32'd0, dout[31:0]});
      end
      8'h03: begin
        dmi_op(addr[3:0], WRITE, data[31:0], rsp);
        check_value({name, " write status"}, expected, 64'(rsp[33:32]));
      end
      8'h04: begin
        dmi_op(addr[3:0], READ, 32'd0, rsp);
        check_value({name, " read"}, expected, 64'(rsp));
      end
      8'h05: check_value({name, " gpio_o"}, expected, 64'(gpio_out));
      8'h06: begin
        rnd = $urandom;
        @(negedge clock);
        gpio_in = rnd[GPIO_W-1:0];
        gpio_rand = rnd[GPIO_W-1:0];
        // give the input synchronizer time
        repeat (8) @(negedge clock);
      end
      8'h07: begin
        dmi_op(addr[3:0], READ, 32'd0, rsp);
        check_value({name, " gpio_i read"}, 64'({expected[1:0], 12'd0, gpio_rand}),
                    64'(rsp));
      end
      8'h08: measure_pwm(name, addr[0], data[31:16], data[15:0], expected);
      8'h0a: provoke_busy(name, addr[3:0], data[31:0], expected);
      default: fail_run({name, ": unknown operation kind in vector file"});
    endcase
  endtask

  initial begin
    int          fd;
    int          n;
    int          lineno;
    string       line;
    logic [63:0] kind;
    logic [63:0] addr;
    logic [63:0] data;
    logic [63:0] expected;
    rst = 1'b1;
    tck = 1'b0;
    tms = 1'b0;
    tdi = 1'b0;
    gpio_in = '0;
    gpio_rand = '0;
    checks = 0;
    lineno = 0;
    void'($urandom(32'h75f03275));
    repeat (8) @(negedge clock);
    rst = 1'b0;
    fd = $fopen("sim/soc_vectors.txt", "r");
    if (fd == 0) begin
      fail_run("could not open sim/soc_vectors.txt");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        lineno++;
        // skip blank and comment lines
        if (n > 1 && line.getc(0) != "#") begin
          n = $sscanf(line, "%h %h %h %h", kind, addr, data, expected);
          if (n != 4) begin
            fail_run($sformatf("line %0d of the vector file is malformed", lineno));
          end else begin
            apply_vector(kind, addr, data, expected, lineno);
          end
        end
      end
      $fclose(fd);
    end
    if (checks == 0) begin
      $display("no checks were run from the vector file");
      $display("Result: FAILED");
      $fatal(1, "empty vector run");
    end else begin
      $display("Result: PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- project.f
+incdir+sim
logic/jtag_pkg.sv
logic/periph_pkg.sv
logic/clk_tick_gen.sv
logic/jtag_tap.sv
logic/periph_regs.sv
logic/pwm_gen.sv
logic/soc_top.sv
sim/soc_top_tb.sv

//--- run_sim.sh
#!/bin/sh
# build with verilator, run, then look for the fail message in the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f project.f --top-module soc_top_tb \
  -o soc_top_tb_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/soc_top_tb_sim > sim.log 2>&1
cat sim.log
grep -q "Result: FAILED" sim.log && exit 1
grep -q "Result: PASSED" sim.log || exit 1
exit 0

//--- sim/soc_vectors.txt
# kind addr data expected, hex; 0 idcode, 1 ir load, 2 dr32 shift, 3 dmi write, 4 dmi read
# 5 gpio_o, 6 random gpio_i, 7 gpio_in read, 8 pwm (addr enable, data period:duty), a busy
0 0 00000000 15c0d54f
1 0 0000001f 00000000
2 0 a5c3f00d 4b87e01a
1 0 00000005 00000000
2 0 00000001 00000002
1 0 00000011 00000000
3 0 000abcde 0
5 0 00000000 000abcde
3 0 fff12345 0
5 0 00000000 00012345
4 0 00000000 000012345
6 0 00000000 0
7 1 00000000 0
3 1 00000123 2
4 9 00000000 200000000
3 f 00000555 2
5 0 00000000 00012345
8 1 00050002 00000008
8 1 00060006 00000018
8 1 00040009 00000010
8 0 00050002 00000000
4 2 00000000 000000005
4 4 00000000 000000000
a 0 00000777 3
5 0 00000000 00000777
0 1 00000000 15c0d54f
